//--- compile.f
source/cache_be_pkg.sv
source/beat_counter.sv
source/line_fetch_ctrl.sv
source/write_lane_align.sv
source/write_channel.sv
source/mem_port_arbiter.sv
source/cache_back_end.sv
verif/be_mem_model.sv
verif/cache_back_end_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator and run it once

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_exe=cache_back_end_sim
log_file=sim.log

verilator --binary --timing -Wno-fatal -f compile.f \
   --top-module cache_back_end_tb --Mdir "$build_dir" -o "$sim_exe"
if [ $? -ne 0 ]; then
   echo "verilator build step returned an error"
   exit 1
fi

"./$build_dir/$sim_exe" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if grep -qx "Regression passed" "$log_file"; then
   exit 0
fi
echo "pass line not found in $log_file"
exit 1

//--- verif/cache_back_end_tb.sv
`default_nettype none

module cache_back_end_tb;

   localparam int WORD_OFF_W  = 3;
   localparam int LINE_LSB    = cache_be_pkg::BE_BYTE_W + WORD_OFF_W - 1;
   localparam int BEATS       = 2 ** (WORD_OFF_W - 1);
   localparam int MEM_WORDS   = 64;
   localparam int N_ENTRIES   = 12;
   localparam int ENTRY_LIMIT = 40;   // worst-case cycles for one entry
   localparam int WATCHDOG_T  = (N_ENTRIES * (ENTRY_LIMIT + 8) + 20) * 10;
   localparam int DRIVE_DELAY = 1;

   localparam logic [1:0] KIND_WRITE  = 2'd0;
   localparam logic [1:0] KIND_REFILL = 2'd1;
   localparam logic [1:0] KIND_BOTH   = 2'd2;

   typedef struct packed {
      logic [1:0]  kind;
      logic [31:0] addr;        // write byte address
      logic [31:0] wdata;
      logic [3:0]  wstrb;
      logic [63:0] exp_wdata;   // write as seen on the bus
      logic [7:0]  exp_wstrb;
      logic [31:0] line;        // refill line byte address
   } entry_t;

   logic                                   clk = 1'b0;
   logic                                   reset;
   logic                                   write_valid;
   cache_be_pkg::wr_req_t                  write_req;
   logic                                   write_ready;
   logic                                   replace_valid;
   logic [cache_be_pkg::ADDR_W-1:LINE_LSB] replace_addr;
   logic                                   replace_ready;
   cache_be_pkg::refill_beat_t             refill;
   cache_be_pkg::mem_req_t                 mem_req;
   logic [63:0]                            mem_rdata;
   logic                                   mem_ready;

   entry_t                     stim [0:N_ENTRIES-1];
   logic [63:0]                shadow [0:MEM_WORDS-1];
   logic [63:0]                exp_beat [0:BEATS-1];
   cache_be_pkg::refill_beat_t beats_seen [$];
   cache_be_pkg::mem_req_t     writes_seen [$];
   cache_be_pkg::mem_req_t     held_req;
   logic                       stalled;
   logic                       watch_first;
   logic                       first_seen;
   logic [7:0]                 first_wstrb;
   int                         errors;
   int                         total_beats;
   int                         stall_cycles;

   always #5 clk = ~clk;

   cache_back_end #(.WORD_OFF_W(WORD_OFF_W)) UUT
     (
      .clk           (clk),
      .reset         (reset),
      .write_valid   (write_valid),
      .write_req     (write_req),
      .write_ready   (write_ready),
      .replace_valid (replace_valid),
      .replace_addr  (replace_addr),
      .replace_ready (replace_ready),
      .refill        (refill),
      .mem_req       (mem_req),
      .mem_rdata     (mem_rdata),
      .mem_ready     (mem_ready)
      );

   be_mem_model #(.WORDS(MEM_WORDS), .SEED(32'h18c7_3c9d)) mem_model
     (
      .clk       (clk),
      .reset     (reset),
      .mem_req   (mem_req),
      .mem_rdata (mem_rdata),
      .mem_ready (mem_ready)
      );

   function automatic logic [63:0] initial_word(input int idx);
      logic [31:0] addr;
      addr = 32'(idx * 8);
      return {addr ^ 32'hc0de_0000, ~addr};
   endfunction

   task automatic load_stimulus();
      //           kind         addr     wdata         strb  bus wdata               bus strb line
      stim[0]  = '{KIND_REFILL, 32'h000, 32'h0000_0000, 4'h0, 64'h0,                  8'h00, 32'h000};
      stim[1]  = '{KIND_WRITE,  32'h008, 32'h1122_3344, 4'hf, 64'h0000_0000_1122_3344, 8'h0f, 32'h000};
      stim[2]  = '{KIND_WRITE,  32'h00c, 32'h5566_7788, 4'h5, 64'h5566_7788_0000_0000, 8'h50, 32'h000};
      stim[3]  = '{KIND_REFILL, 32'h000, 32'h0000_0000, 4'h0, 64'h0,                  8'h00, 32'h000};
      stim[4]  = '{KIND_WRITE,  32'h024, 32'hdead_beef, 4'h3, 64'hdead_beef_0000_0000, 8'h30, 32'h000};
      stim[5]  = '{KIND_BOTH,   32'h030, 32'hcafe_f00d, 4'hf, 64'h0000_0000_cafe_f00d, 8'h0f, 32'h020};
      stim[6]  = '{KIND_REFILL, 32'h000, 32'h0000_0000, 4'h0, 64'h0,                  8'h00, 32'h020};
      stim[7]  = '{KIND_WRITE,  32'h1f8, 32'h0bad_c0de, 4'h8, 64'h0000_0000_0bad_c0de, 8'h08, 32'h000};
      stim[8]  = '{KIND_WRITE,  32'h1fc, 32'h1357_9bdf, 4'he, 64'h1357_9bdf_0000_0000, 8'he0, 32'h000};
      stim[9]  = '{KIND_REFILL, 32'h000, 32'h0000_0000, 4'h0, 64'h0,                  8'h00, 32'h1e0};
      stim[10] = '{KIND_BOTH,   32'h044, 32'ha5a5_5a5a, 4'h9, 64'ha5a5_5a5a_0000_0000, 8'h90, 32'h040};
      stim[11] = '{KIND_REFILL, 32'h000, 32'h0000_0000, 4'h0, 64'h0,                  8'h00, 32'h040};
   endtask

   task automatic report_mismatch(input string name, input logic [63:0] expected,
                                  input logic [63:0] actual);
      errors++;
      $display("Error %s expected %h got %h", name, expected, actual);
   endtask

   // shadow byte merge in the lane that address bit 2 picks
   task automatic merge_write(input entry_t e);
      int w;
      int lane;
      w    = int'(e.addr[8:3]);
      lane = e.addr[2] ? 4 : 0;
      for (int b = 0; b < 4; b++)
         if (e.wstrb[b])
            shadow[w][(lane + b) * 8 +: 8] = e.wdata[b * 8 +: 8];
   endtask

   task automatic check_entry(input int i, input entry_t cur);
      cache_be_pkg::mem_req_t wr;
      int                     n_beats;
      n_beats = (cur.kind == KIND_WRITE) ? 0 : BEATS;
      total_beats += beats_seen.size();
      if (beats_seen.size() != n_beats)
      begin
         errors++;
         $display("entry %0d gave %0d refill beats instead of %0d", i, beats_seen.size(), n_beats);
      end
      else
         for (int k = 0; k < n_beats; k++)
         begin
            if (int'(beats_seen[k].index) != k)
               report_mismatch("refill.index", 64'(k), 64'(beats_seen[k].index));
            if (beats_seen[k].rdata !== exp_beat[k])
               report_mismatch("refill.rdata", exp_beat[k], beats_seen[k].rdata);
         end
      if (cur.kind == KIND_REFILL)
      begin
         if (writes_seen.size() != 0)
         begin
            errors++;
            $display("entry %0d put a write on the bus during a plain refill", i);
         end
      end
      else if (writes_seen.size() != 1)
      begin
         errors++;
         $display("entry %0d put %0d writes on the bus instead of one", i, writes_seen.size());
      end
      else
      begin
         wr = writes_seen[0];
         if (wr.addr !== {cur.addr[31:3], 3'b000})
            report_mismatch("mem_req.addr", 64'({cur.addr[31:3], 3'b000}), 64'(wr.addr));
         if (wr.wdata !== cur.exp_wdata)
            report_mismatch("mem_req.wdata", cur.exp_wdata, wr.wdata);
         if (wr.wstrb !== cur.exp_wstrb)
            report_mismatch("mem_req.wstrb", 64'(cur.exp_wstrb), 64'(wr.wstrb));
      end
      if (cur.kind == KIND_BOTH)
      begin
         if (!first_seen)
         begin
            errors++;
            $display("entry %0d never showed a memory request", i);
         end
         else if (first_wstrb !== 8'h00)
            report_mismatch("first mem_req.wstrb", 64'h0, 64'(first_wstrb));   // read goes first
      end
   endtask

   // bus monitor sampling mid-cycle
   always @(negedge clk)
   begin
      if (!reset)
      begin
         if (stalled && (mem_req !== held_req))
         begin
            errors++;
            $display("Error mem_req expected %h got %h", held_req, mem_req);
         end
         if (refill.valid)
            beats_seen.push_back(refill);
         if (mem_req.valid && mem_ready && (mem_req.wstrb != 8'h00))
            writes_seen.push_back(mem_req);
         if (watch_first && mem_req.valid)
         begin
            first_wstrb = mem_req.wstrb;
            first_seen  = 1'b1;
            watch_first = 1'b0;
         end
         if (mem_req.valid && !mem_ready)
            stall_cycles++;
         stalled  = mem_req.valid && !mem_ready;
         held_req = mem_req;
      end
   end

   initial
   begin : main
      entry_t cur;
      int     cycles;
      int     base;
      reset         = 1'b1;
      write_valid   = 1'b0;
      write_req     = '0;
      replace_valid = 1'b0;
      replace_addr  = '0;
      errors        = 0;
      total_beats   = 0;
      stall_cycles  = 0;
      stalled       = 1'b0;
      watch_first   = 1'b0;
      first_seen    = 1'b0;
      load_stimulus();
      for (int w = 0; w < MEM_WORDS; w++)
         shadow[w] = initial_word(w);
      repeat (4) @(posedge clk);
      #DRIVE_DELAY reset = 1'b0;
      @(negedge clk);
      if (replace_ready !== 1'b1)
         report_mismatch("replace_ready", 64'h1, 64'(replace_ready));
      if (write_ready !== 1'b1)
         report_mismatch("write_ready", 64'h1, 64'(write_ready));
      if (mem_req.valid !== 1'b0)
         report_mismatch("mem_req.valid", 64'h0, 64'(mem_req.valid));
      if (refill.valid !== 1'b0)
         report_mismatch("refill.valid", 64'h0, 64'(refill.valid));
      for (int i = 0; i < N_ENTRIES; i++)
      begin
         cur  = stim[i];
         base = int'(cur.line[8:3]);
         for (int k = 0; k < BEATS; k++)
            exp_beat[k] = shadow[base + k];   // reads go before the write
         if (cur.kind != KIND_REFILL)
            merge_write(cur);
         beats_seen.delete();
         writes_seen.delete();
         first_seen  = 1'b0;
         watch_first = (cur.kind == KIND_BOTH);
         @(posedge clk);
         #DRIVE_DELAY;
         write_valid   = (cur.kind != KIND_REFILL);
         write_req     = '{cur.addr, cur.wdata, cur.wstrb};
         replace_valid = (cur.kind != KIND_WRITE);
         replace_addr  = cur.line[cache_be_pkg::ADDR_W-1:LINE_LSB];
         @(posedge clk);
         #DRIVE_DELAY;
         write_valid   = 1'b0;
         replace_valid = 1'b0;
         cycles = 0;
         @(negedge clk);
         while (!(write_ready && replace_ready) && (cycles < ENTRY_LIMIT))
         begin
            @(negedge clk);
            cycles++;
         end
         if (!(write_ready && replace_ready))
         begin
            errors++;
            $display("entry %0d did not finish within %0d cycles", i, ENTRY_LIMIT);
         end
         check_entry(i, cur);
      end
      if (stall_cycles == 0)
      begin
         errors++;
         $display("memory never held back a request, so bus stability went untested");
      end
      $display("entries %0d, refill beats %0d, stalled cycles %0d, errors %0d",
               N_ENTRIES, total_beats, stall_cycles, errors);
      if (errors == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

   initial
   begin
      #(WATCHDOG_T);
      $display("watchdog expired after %0d time units, run stopped", WATCHDOG_T);
      $display("Regression failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- verif/be_mem_model.sv
`default_nettype none

module be_mem_model
  #(
    parameter int          WORDS = 64,
    parameter logic [31:0] SEED  = 32'h18c7_3c9d
    )
   (
    input  wire                                clk,
    input  wire                                reset,
    input  wire cache_be_pkg::mem_req_t        mem_req,
    output logic [cache_be_pkg::BE_DATA_W-1:0] mem_rdata,
    output logic                               mem_ready
    );

   localparam int IDX_W = $clog2(WORDS);

   logic [cache_be_pkg::BE_DATA_W-1:0] mem [0:WORDS-1];
   logic [IDX_W-1:0]                   idx;
   logic [1:0]                         wait_cnt;   // cycles left before the answer
   integer                             seed;
   integer                             rnd;

   // known start content, a function of the full byte address
   function automatic logic [63:0] fill_word(input logic [31:0] addr);
      return {addr ^ 32'hc0de_0000, ~addr};
   endfunction

   initial
   begin
      seed = SEED;
      for (int i = 0; i < WORDS; i++)
         mem[i] = fill_word(32'(i * 8));
   end

   assign idx       = mem_req.addr[IDX_W+2:3];
   assign mem_ready = mem_req.valid && (wait_cnt == 2'd0);
   assign mem_rdata = mem[idx];

   // next delay is drawn when a transfer completes
   always @(posedge clk or posedge reset)
   begin
      if (reset)
         wait_cnt <= 2'd0;
      else if (mem_ready)
      begin
         rnd = $random(seed);
         wait_cnt <= rnd[1:0];   // 0 to 3 cycles
      end
      else if (mem_req.valid)
         wait_cnt <= wait_cnt - 2'd1;
   end

   always @(posedge clk)
   begin
      if (mem_req.valid && mem_ready)
         for (int b = 0; b < cache_be_pkg::BE_NBYTES; b++)
            if (mem_req.wstrb[b])
               mem[idx][b*8 +: 8] <= mem_req.wdata[b*8 +: 8];   // byte merge
   end

endmodule

`default_nettype wire

//--- source/cache_back_end.sv
`default_nettype none

module cache_back_end
  #(
    parameter  int WORD_OFF_W = cache_be_pkg::WORD_OFF_W,   // 2**WORD_OFF_W cache words per line
    localparam int LINE_LSB   = cache_be_pkg::BE_BYTE_W + WORD_OFF_W - 1
    )
   (
    input  wire                                   clk,
    input  wire                                   reset,
    // write-through side
    input  wire                                   write_valid,
    input  wire cache_be_pkg::wr_req_t            write_req,
    output logic                                  write_ready,
    // line replacement side
    input  wire                                   replace_valid,
    input  wire [cache_be_pkg::ADDR_W-1:LINE_LSB] replace_addr,
    output logic                                  replace_ready,
    output cache_be_pkg::refill_beat_t            refill,
    // memory bus
    output cache_be_pkg::mem_req_t                mem_req,
    input  wire [cache_be_pkg::BE_DATA_W-1:0]     mem_rdata,
    input  wire                                   mem_ready
    );

   logic [WORD_OFF_W-2:0]  count;
   logic                   last_beat;
   logic                   clear;
   logic                   advance;
   cache_be_pkg::mem_req_t rd_req;
   cache_be_pkg::mem_req_t wr_mem_req;
   logic                   rd_mem_ready;
   logic                   wr_mem_ready;

   beat_counter #(.WORD_OFF_W(WORD_OFF_W)) beat_cnt
     (
      .clk       (clk),
      .reset     (reset),
      .clear     (clear),
      .advance   (advance),
      .count     (count),
      .last_beat (last_beat)
      );

   line_fetch_ctrl #(.WORD_OFF_W(WORD_OFF_W)) fetch_ctrl
     (
      .clk           (clk),
      .reset         (reset),
      .replace_valid (replace_valid),
      .replace_addr  (replace_addr),
      .replace_ready (replace_ready),
      .refill        (refill),
      .rd_req        (rd_req),
      .rd_mem_ready  (rd_mem_ready),
      .mem_rdata     (mem_rdata),
      .count         (count),
      .last_beat     (last_beat),
      .clear         (clear),
      .advance       (advance)
      );

   write_channel wr_chan
     (
      .clk          (clk),
      .reset        (reset),
      .write_valid  (write_valid),
      .write_req    (write_req),
      .write_ready  (write_ready),
      .wr_mem_req   (wr_mem_req),
      .wr_mem_ready (wr_mem_ready)
      );

   mem_port_arbiter port_arb
     (
      .clk          (clk),
      .reset        (reset),
      .rd_req       (rd_req),
      .wr_req       (wr_mem_req),
      .mem_req      (mem_req),
      .mem_ready    (mem_ready),
      .rd_mem_ready (rd_mem_ready),
      .wr_mem_ready (wr_mem_ready)
      );

endmodule

`default_nettype wire

//--- source/mem_port_arbiter.sv
`default_nettype none

module mem_port_arbiter
   (
    input  wire                         clk,
    input  wire                         reset,
    input  wire cache_be_pkg::mem_req_t rd_req,
    input  wire cache_be_pkg::mem_req_t wr_req,
    output cache_be_pkg::mem_req_t      mem_req,
    input  wire                         mem_ready,
    output logic                        rd_mem_ready,
    output logic                        wr_mem_ready
    );

   logic held;       // grant kept until mem_ready
   logic owner_rd;   // grant holder, set for the refill side
   logic sel_rd;

   // an open port goes to the read side first
   assign sel_rd = held ? owner_rd : rd_req.valid;

   assign mem_req = sel_rd ? rd_req : wr_req;

   // only the owner sees the memory answer
   assign rd_mem_ready = mem_ready && mem_req.valid && sel_rd;
   assign wr_mem_ready = mem_ready && mem_req.valid && !sel_rd;

   always_ff @(posedge clk, posedge reset)
   begin
      if (reset)
      begin
         held     <= 1'b0;
         owner_rd <= 1'b0;
      end
      else
      begin
         held <= mem_req.valid && !mem_ready;   // stalled transfer keeps its grant
         if (mem_req.valid)
         begin
            owner_rd <= sel_rd;
         end
      end
   end

endmodule

`default_nettype wire

//--- source/write_channel.sv
`default_nettype none

module write_channel
   (
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        write_valid,
    input  wire cache_be_pkg::wr_req_t write_req,
    output logic                       write_ready,
    output cache_be_pkg::mem_req_t     wr_mem_req,
    input  wire                        wr_mem_ready
    );

   typedef enum logic {idle, busy} state_t;

   state_t                             state;
   cache_be_pkg::wr_req_t              req_q;        // accepted write
   logic [cache_be_pkg::BE_DATA_W-1:0] lane_wdata;
   logic [cache_be_pkg::BE_NBYTES-1:0] lane_wstrb;

   always_ff @(posedge clk, posedge reset)
   begin
      if (reset)
      begin
         state <= idle;
      end
      else if (state == idle)
      begin
         if (write_valid)
         begin
            state <= busy;
         end
      end
      else if (wr_mem_ready)
      begin
         state <= idle;   // ready again next cycle
      end
   end

   always_ff @(posedge clk)
   begin
      if (write_valid && write_ready)
      begin
         req_q <= write_req;
      end
   end

   write_lane_align lane_align
     (
      .req       (req_q),
      .mem_wdata (lane_wdata),
      .mem_wstrb (lane_wstrb)
      );

   assign write_ready = (state == idle);

   always_comb
   begin
      wr_mem_req.valid = (state == busy);
      wr_mem_req.addr  = {req_q.addr[cache_be_pkg::ADDR_W-1:cache_be_pkg::BE_BYTE_W],
                          {cache_be_pkg::BE_BYTE_W{1'b0}}};
      wr_mem_req.wdata = lane_wdata;
      wr_mem_req.wstrb = (state == busy) ? lane_wstrb : '0;   // no strobes when idle
   end

endmodule

`default_nettype wire

//--- source/write_lane_align.sv
`default_nettype none

module write_lane_align
   (
    input  wire cache_be_pkg::wr_req_t         req,
    output logic [cache_be_pkg::BE_DATA_W-1:0] mem_wdata,
    output logic [cache_be_pkg::BE_NBYTES-1:0] mem_wstrb
    );

   localparam int LANE_BIT = cache_be_pkg::BE_BYTE_W - 1;   // picks the 32 bit half
   localparam int PAD_D    = cache_be_pkg::BE_DATA_W - cache_be_pkg::FE_DATA_W;
   localparam int PAD_S    = cache_be_pkg::BE_NBYTES - cache_be_pkg::FE_NBYTES;

   logic [cache_be_pkg::BE_DATA_W-1:0] wdata_low;
   logic [cache_be_pkg::BE_NBYTES-1:0] wstrb_low;

   // word and strobes placed in the low lane first
   assign wdata_low = {{PAD_D{1'b0}}, req.wdata};
   assign wstrb_low = {{PAD_S{1'b0}}, req.wstrb};

   always_comb
   begin
      if (req.addr[LANE_BIT])
      begin
         mem_wdata = wdata_low << cache_be_pkg::FE_DATA_W;   // upper lane
         mem_wstrb = wstrb_low << cache_be_pkg::FE_NBYTES;
      end
      else
      begin
         mem_wdata = wdata_low;
         mem_wstrb = wstrb_low;
      end
   end

endmodule

`default_nettype wire

//--- source/line_fetch_ctrl.sv
`default_nettype none

module line_fetch_ctrl
  #(
    parameter  int WORD_OFF_W = 3,
    localparam int LINE_LSB   = cache_be_pkg::BE_BYTE_W + WORD_OFF_W - 1
    )
   (
    input  wire                                   clk,
    input  wire                                   reset,
    input  wire                                   replace_valid,
    input  wire [cache_be_pkg::ADDR_W-1:LINE_LSB] replace_addr,
    output logic                                  replace_ready,
    output cache_be_pkg::refill_beat_t            refill,
    output cache_be_pkg::mem_req_t                rd_req,
    input  wire                                   rd_mem_ready,
    input  wire [cache_be_pkg::BE_DATA_W-1:0]     mem_rdata,
    input  wire [WORD_OFF_W-2:0]                  count,
    input  wire                                   last_beat,
    output logic                                  clear,
    output logic                                  advance
    );

   localparam int IDX_W = cache_be_pkg::BEAT_IDX_W;

   typedef enum logic [1:0] {idle, fetch, finish} state_t;

   state_t                                state;
   logic [cache_be_pkg::ADDR_W-1:LINE_LSB] line_addr;   // latched line being refilled
   logic                                  beat_done;

   assign beat_done = (state == fetch) && rd_mem_ready;

   always_ff @(posedge clk, posedge reset)
   begin
      if (reset)
      begin
         state <= idle;
      end
      else
      begin
         case (state)
            idle:
            begin
               if (replace_valid)
               begin
                  state <= fetch;
               end
            end
            fetch:
            begin
               if (beat_done && last_beat)
               begin
                  state <= finish;
               end
            end
            default:
            begin
               state <= idle;   // single end cycle
            end
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (replace_valid && replace_ready)
      begin
         line_addr <= replace_addr;
      end
   end

   assign replace_ready = (state == idle);
   assign clear         = (state == idle);   // start every line at beat 0
   assign advance       = beat_done;

   // beat address is line address plus beat count
   always_comb
   begin
      rd_req.valid = (state == fetch);
      rd_req.addr  = {line_addr, count, {cache_be_pkg::BE_BYTE_W{1'b0}}};
      rd_req.wdata = '0;
      rd_req.wstrb = '0;                     // read
   end

   always_comb
   begin
      refill.valid = beat_done;              // same cycle as mem_ready
      refill.index = IDX_W'(count);
      refill.rdata = mem_rdata;
   end

endmodule

`default_nettype wire

//--- source/beat_counter.sv
`default_nettype none

module beat_counter
  #(
    parameter int WORD_OFF_W = 3
    )
   (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   clear,     // back to beat 0
    input  wire                   advance,   // one beat accepted
    output logic [WORD_OFF_W-2:0] count,
    output logic                  last_beat
    );

   always_ff @(posedge clk, posedge reset)
   begin
      if (reset)
      begin
         count <= '0;
      end
      else if (clear)
      begin
         count <= '0;
      end
      else if (advance)
      begin
         count <= count + 1'b1;   // wraps to 0 after the last beat
      end
   end

   assign last_beat = &count;     // final beat of the line

endmodule

`default_nettype wire

//--- source/cache_be_pkg.sv
`default_nettype none

package cache_be_pkg;

   localparam int ADDR_W    = 32;              // byte address
   localparam int FE_DATA_W = 32;              // cache side word
   localparam int FE_NBYTES = FE_DATA_W / 8;
   localparam int BE_DATA_W = 64;              // memory side word
   localparam int BE_NBYTES = BE_DATA_W / 8;
   localparam int BE_BYTE_W = $clog2(BE_NBYTES);  // byte offset inside a memory word

   // line size the refill beat index is sized for
   localparam int WORD_OFF_W = 3;
   localparam int BEAT_IDX_W = WORD_OFF_W - 1;  // two cache words per beat

   typedef struct packed {
      logic                 valid;
      logic [ADDR_W-1:0]    addr;   // memory word aligned
      logic [BE_DATA_W-1:0] wdata;
      logic [BE_NBYTES-1:0] wstrb;  // all zero on reads
   } mem_req_t;

   typedef struct packed {
      logic [ADDR_W-1:0]    addr;   // low two bits unused
      logic [FE_DATA_W-1:0] wdata;
      logic [FE_NBYTES-1:0] wstrb;
   } wr_req_t;

   typedef struct packed {
      logic                  valid;
      logic [BEAT_IDX_W-1:0] index;  // beat number within the line
      logic [BE_DATA_W-1:0]  rdata;
   } refill_beat_t;

endpackage

`default_nettype wire
